/* design/anticPkg.sv */
// Display-list opcodes, sequencer states, playfield widths and byte-count rules
`default_nettype none

package anticPkg;

  // Low nibble of a display-list instruction; the remaining codes are unsupported
  typedef enum logic [3:0] {
    opBlank = 4'd0,
    opJump  = 4'd1,
    opChar2 = 4'd2,
    opMap14 = 4'd14
  } dlOpcode_t;

  typedef enum logic [3:0] {
    stIdle,
    stDecode,
    stBlank,
    stFetchLo,
    stFetchHi,
    stJumpLoad,
    stJumpEnd,
    stVblankWait,
    stModeBusy
  } seqState_t;

  // Playfield width as coded in DMA control bits 1-0
  typedef enum logic [1:0] {pfNone, pfNarrow, pfStandard, pfWide} pfWidth_t;

  localparam int charBits = 64;
  localparam int mapPixelsPerByte = 4;
  localparam int charScanLines = 8;
  localparam int mapScanLines = 1;

  // Bytes fetched per mode line for the wide-byte modes
  function automatic logic [6:0] charBytes(pfWidth_t width);
    case (width)
      pfNarrow:   return 7'd32;
      pfStandard: return 7'd40;
      pfWide:     return 7'd48;
      default:    return 7'd0;
    endcase
  endfunction

endpackage

`default_nettype wire

/* design/gtiaPkg.sv */
// AN codes sent to the colour chip and the map-mode pixel colour table
`default_nettype none

package gtiaPkg;

  typedef enum logic [3:0] {
    anNone       = 4'b0000,
    anBackground = 4'b1000,
    anPlayfield0 = 4'b1100,
    anPlayfield1 = 4'b1101,
    anPlayfield2 = 4'b1110,
    anPlayfield3 = 4'b1111
  } anCode_t;

  typedef logic [1:0] mapPixel_t;

  // A two-bit map pixel selects background or one of the first three playfields
  function automatic anCode_t mapColour(mapPixel_t value);
    case (value)
      2'd0:    return anBackground;
      2'd1:    return anPlayfield0;
      2'd2:    return anPlayfield1;
      default: return anPlayfield2;
    endcase
  endfunction

endpackage

`default_nettype wire

/* design/modeLineIf.sv */
// Mode-line handover between the instruction sequencer and the playfield serializer
`timescale 1ns/100ps
`default_nettype none

interface modeLineIf;
  import anticPkg::*;

  logic       start;
  dlOpcode_t  mode;
  logic       irHold;
  logic       done;
  logic [3:0] scanLines;

  modport sequencer (output start, output mode, output irHold, input done);

  modport serializer (input start, input mode, input irHold, output done, output scanLines);

  // Line-end observer used by the scan-line counter
  modport monitor (input done, input scanLines);

endinterface

`default_nettype wire

/* design/dlistSequencer.sv */
// Display-list instruction sequencer: blank lines, jumps, memory-scan load and
// the vertical-blank wait, handing display modes to the serializer
`timescale 1ns/100ps
`default_nettype none

module dlistSequencer #(
  parameter int vblankCycles = 5012
) (
  input  logic         Fphi0,
  input  logic         rst,
  input  logic         advance,
  input  logic [7:0]   ir,
  input  logic         irRdy,
  modeLineIf.sequencer lineBus,
  output logic         blankLine,
  output logic         vblankClear,
  output logic         loadIr,
  output logic         loadDlistL,
  output logic         loadDlistH,
  output logic         loadPtr,
  output logic         loadDlist,
  output logic         loadMsrL,
  output logic         loadMsrH,
  output logic         dlistEnd
);
  import anticPkg::*;

  localparam int vbW = $clog2(vblankCycles + 1);

  seqState_t      state;
  logic [7:0]     irReg;
  logic [2:0]     blankCnt;
  logic [vbW-1:0] vblankCnt;
  logic           isJump;

  assign isJump = (irReg[3:0] == opJump);

  always_ff @(posedge Fphi0) begin
    if (advance && state == stIdle && irRdy) begin
      irReg <= ir;
    end
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state          <= stIdle;
      blankCnt       <= 3'd0;
      vblankCnt      <= '0;
      lineBus.start  <= 1'b0;
      lineBus.mode   <= opBlank;
      lineBus.irHold <= 1'b0;
      blankLine      <= 1'b0;
      vblankClear    <= 1'b0;
      loadIr         <= 1'b0;
      loadDlistL     <= 1'b0;
      loadDlistH     <= 1'b0;
      loadPtr        <= 1'b0;
      loadDlist      <= 1'b0;
      loadMsrL       <= 1'b0;
      loadMsrH       <= 1'b0;
      dlistEnd       <= 1'b0;
    end else if (advance) begin
      // Every strobe lasts a single advancing cycle
      lineBus.start <= 1'b0;
      blankLine     <= 1'b0;
      vblankClear   <= 1'b0;
      loadIr        <= 1'b0;
      loadDlistL    <= 1'b0;
      loadDlistH    <= 1'b0;
      loadPtr       <= 1'b0;
      loadDlist     <= 1'b0;
      loadMsrL      <= 1'b0;
      loadMsrH      <= 1'b0;
      dlistEnd      <= 1'b0;
      case (state)
        stIdle: begin
          if (irRdy) begin
            state <= stDecode;
          end
        end
        stDecode: begin
          case (irReg[3:0])
            opBlank: begin
              // First blank line goes out now, the rest are counted down
              blankLine <= 1'b1;
              blankCnt  <= irReg[6:4];
              state     <= stBlank;
            end
            opJump: begin
              loadIr <= 1'b1;
              state  <= stFetchLo;
            end
            opChar2, opMap14: begin
              lineBus.mode   <= dlOpcode_t'(irReg[3:0]);
              lineBus.irHold <= 1'b1;
              if (irReg[6]) begin
                loadIr <= 1'b1;
                state  <= stFetchLo;
              end else begin
                lineBus.start <= 1'b1;
                state         <= stModeBusy;
              end
            end
            default: begin
              loadIr <= 1'b1;
              state  <= stIdle;
            end
          endcase
        end
        stBlank: begin
          if (blankCnt != 3'd0) begin
            blankLine <= 1'b1;
            blankCnt  <= blankCnt - 3'd1;
          end else begin
            loadIr <= 1'b1;
            state  <= stIdle;
          end
        end
        stFetchLo: begin
          if (irRdy) begin
            loadIr     <= 1'b1;
            loadDlistL <= isJump;
            loadPtr    <= isJump;
            loadMsrL   <= !isJump;
            state      <= stFetchHi;
          end
        end
        stFetchHi: begin
          if (irRdy) begin
            if (isJump) begin
              loadDlistH <= 1'b1;
              state      <= stJumpLoad;
            end else begin
              loadMsrH      <= 1'b1;
              lineBus.start <= 1'b1;
              state         <= stModeBusy;
            end
          end
        end
        stJumpLoad: begin
          loadDlist <= 1'b1;
          if (irReg[6]) begin
            // Jump-and-wait closes the list until vertical blank is over
            dlistEnd  <= 1'b1;
            vblankCnt <= '0;
            state     <= stVblankWait;
          end else begin
            state <= stJumpEnd;
          end
        end
        stJumpEnd: begin
          loadIr <= 1'b1;
          state  <= stIdle;
        end
        stVblankWait: begin
          vblankCnt <= vblankCnt + 1'b1;
          if (vblankCnt == vbW'(vblankCycles - 1)) begin
            vblankClear <= 1'b1;
            loadIr      <= 1'b1;
            state       <= stIdle;
          end
        end
        stModeBusy: begin
          if (lineBus.done) begin
            lineBus.irHold <= 1'b0;
            loadIr         <= 1'b1;
            state          <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Both display-list address bytes must never land in the same cycle
  assert property (@(posedge Fphi0) disable iff (rst) !(loadDlistL && loadDlistH));

endmodule

`default_nettype wire

/* design/playfieldSerializer.sv */
// Playfield serializer: fetches mode-line bytes and shifts out character-mode
// or map-mode pixels as AN codes
`timescale 1ns/100ps
`default_nettype none

module playfieldSerializer (
  input  logic               Fphi0,
  input  logic               rst,
  input  logic               advance,
  modeLineIf.serializer      lineBus,
  input  anticPkg::pfWidth_t pfWidth,
  input  logic [7:0]         msrData,
  input  logic               msrDataRdy,
  input  logic [63:0]        charData,
  input  logic               charLoaded,
  output logic               loadMsrData,
  output logic               incrMsr,
  output logic               loadChar,
  output gtiaPkg::anCode_t   pixel,
  output logic               pixelValid
);
  import anticPkg::*;
  import gtiaPkg::*;

  typedef enum logic [1:0] {serIdle, serMsrWait, serCharWait, serShift} serState_t;

  serState_t  state;
  logic       isChar;
  logic [6:0] byteCnt;
  logic [6:0] bitIdx;
  logic [1:0] pixIdx;
  logic       repeatFlag;
  logic [7:0] msrByte;
  logic       byteLast;

  // Last pixel of the current byte; a map pixel ends on its second copy
  assign byteLast = isChar ? (bitIdx == 7'(charBits - 1))
                           : (repeatFlag && pixIdx == 2'(mapPixelsPerByte - 1));

  always_ff @(posedge Fphi0) begin
    if (advance && state == serMsrWait && msrDataRdy) begin
      msrByte <= msrData;
    end
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state             <= serIdle;
      isChar            <= 1'b0;
      byteCnt           <= 7'd0;
      bitIdx            <= 7'd0;
      pixIdx            <= 2'd0;
      repeatFlag        <= 1'b0;
      loadMsrData       <= 1'b0;
      incrMsr           <= 1'b0;
      loadChar          <= 1'b0;
      pixel             <= anNone;
      pixelValid        <= 1'b0;
      lineBus.done      <= 1'b0;
      lineBus.scanLines <= 4'd0;
    end else if (advance) begin
      loadMsrData  <= 1'b0;
      incrMsr      <= 1'b0;
      loadChar     <= 1'b0;
      pixelValid   <= 1'b0;
      lineBus.done <= 1'b0;
      case (state)
        serIdle: begin
          if (lineBus.start && lineBus.irHold) begin
            isChar            <= (lineBus.mode == opChar2);
            lineBus.scanLines <= (lineBus.mode == opChar2) ? 4'(charScanLines)
                                                           : 4'(mapScanLines);
            byteCnt           <= charBytes(pfWidth);
            if (pfWidth == pfNone) begin
              // No playfield, so the line is finished without any fetch
              lineBus.done <= 1'b1;
            end else begin
              loadMsrData <= 1'b1;
              incrMsr     <= 1'b1;
              state       <= serMsrWait;
            end
          end
        end
        serMsrWait: begin
          if (msrDataRdy) begin
            if (isChar) begin
              loadChar <= 1'b1;
              state    <= serCharWait;
            end else begin
              pixIdx     <= 2'd0;
              repeatFlag <= 1'b0;
              state      <= serShift;
            end
          end
        end
        serCharWait: begin
          if (charLoaded) begin
            bitIdx <= 7'd0;
            state  <= serShift;
          end
        end
        serShift: begin
          pixelValid <= 1'b1;
          if (isChar) begin
            // Set bits are the foreground colour, clear bits the background
            pixel  <= charData[bitIdx[5:0]] ? anPlayfield1 : anPlayfield2;
            bitIdx <= byteLast ? 7'd0 : bitIdx + 7'd1;
          end else begin
            pixel      <= mapColour({msrByte[{pixIdx, 1'b0}], msrByte[{pixIdx, 1'b1}]});
            repeatFlag <= !repeatFlag;
            if (repeatFlag) begin
              pixIdx <= pixIdx + 2'd1;
            end
          end
          if (byteLast) begin
            byteCnt <= byteCnt - 7'd1;
            if (byteCnt == 7'd1) begin
              lineBus.done <= 1'b1;
              state        <= serIdle;
            end else begin
              loadMsrData <= 1'b1;
              incrMsr     <= 1'b1;
              state       <= serMsrWait;
            end
          end
        end
        default: state <= serIdle;
      endcase
    end
  end

  assert property (@(posedge Fphi0) disable iff (rst)
    (state == serShift && isChar) |-> bitIdx < 7'(charBits));

endmodule

`default_nettype wire

/* design/scanlineOutput.sv */
// Output stage: registered AN code, scan-line count, line-sync pulse and the
// global advance enable
`timescale 1ns/100ps
`default_nettype none

module scanlineOutput (
  input  logic             Fphi0,
  input  logic             rst,
  input  logic             dma,
  input  logic             rdy,
  input  gtiaPkg::anCode_t pixel,
  input  logic             pixelValid,
  input  logic             blankLine,
  modeLineIf.monitor       lineBus,
  input  logic             vblankClear,
  input  logic             dlistEnd,
  output logic             advance,
  output gtiaPkg::anCode_t an,
  output logic [7:0]       vcount,
  output logic             updateWsync
);
  import gtiaPkg::*;

  logic vblankHold;

  // The translator freezes while DMA owns the bus and the memory is not ready
  assign advance = !(dma && !rdy);

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      an <= anNone;
    end else if (!advance) begin
      an <= anNone;
    end else begin
      an <= pixelValid ? pixel : anNone;
    end
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      vcount      <= 8'd0;
      vblankHold  <= 1'b0;
      updateWsync <= 1'b0;
    end else if (advance) begin
      if (vblankClear) begin
        vcount <= 8'd0;
      end else if (lineBus.done) begin
        vcount <= vcount + 8'(lineBus.scanLines);
      end else if (blankLine) begin
        vcount <= vcount + 8'd1;
      end
      // Sync stays up for the whole vertical-blank wait
      if (dlistEnd) begin
        vblankHold <= 1'b1;
      end else if (vblankClear) begin
        vblankHold <= 1'b0;
      end
      updateWsync <= lineBus.done || dlistEnd || (vblankHold && !vblankClear);
    end
  end

  // A stalled cycle must never leak a pixel on the following cycle
  assert property (@(posedge Fphi0) disable iff (rst) !advance |=> an == anNone);

endmodule

`default_nettype wire

/* design/dataTranslate.sv */
// Display-list translator top level: sequencer, serializer and output stage
`timescale 1ns/100ps
`default_nettype none

module dataTranslate #(
  parameter int vblankCycles = 5012
) (
  input  logic             Fphi0,
  input  logic             rst,
  input  logic [7:0]       ir,
  input  logic             irRdy,
  input  logic [7:0]       dmactl,
  input  logic [7:0]       msrData,
  input  logic             msrDataRdy,
  input  logic [63:0]      charData,
  input  logic             charLoaded,
  input  logic             dma,
  input  logic             rdy,
  output logic             loadIr,
  output logic             loadDlistL,
  output logic             loadDlistH,
  output logic             loadPtr,
  output logic             loadDlist,
  output logic             loadMsrL,
  output logic             loadMsrH,
  output logic             loadMsrData,
  output logic             incrMsr,
  output logic             loadChar,
  output gtiaPkg::anCode_t an,
  output logic [7:0]       vcount,
  output logic             updateWsync,
  output logic             dlistEnd
);
  import anticPkg::*;
  import gtiaPkg::*;

  logic     advance;
  logic     blankLine;
  logic     vblankClear;
  logic     pixelValid;
  anCode_t  pixel;
  pfWidth_t pfWidth;

  // Playfield width lives in the two low bits of the DMA control byte
  assign pfWidth = pfWidth_t'(dmactl[1:0]);

  modeLineIf lineBus ();

  dlistSequencer #(
    .vblankCycles(vblankCycles)
  ) sequencer0 (
    .Fphi0(Fphi0), .rst(rst), .advance(advance), .ir(ir), .irRdy(irRdy),
    .lineBus(lineBus.sequencer), .blankLine(blankLine), .vblankClear(vblankClear),
    .loadIr(loadIr), .loadDlistL(loadDlistL), .loadDlistH(loadDlistH), .loadPtr(loadPtr),
    .loadDlist(loadDlist), .loadMsrL(loadMsrL), .loadMsrH(loadMsrH), .dlistEnd(dlistEnd)
  );

  playfieldSerializer serializer0 (
    .Fphi0(Fphi0), .rst(rst), .advance(advance), .lineBus(lineBus.serializer),
    .pfWidth(pfWidth), .msrData(msrData), .msrDataRdy(msrDataRdy), .charData(charData),
    .charLoaded(charLoaded), .loadMsrData(loadMsrData), .incrMsr(incrMsr),
    .loadChar(loadChar), .pixel(pixel), .pixelValid(pixelValid)
  );

  scanlineOutput output0 (
    .Fphi0(Fphi0), .rst(rst), .dma(dma), .rdy(rdy), .pixel(pixel),
    .pixelValid(pixelValid), .blankLine(blankLine), .lineBus(lineBus.monitor),
    .vblankClear(vblankClear), .dlistEnd(dlistEnd), .advance(advance), .an(an),
    .vcount(vcount), .updateWsync(updateWsync)
  );

endmodule

`default_nettype wire

/* verif/anChecker.sv */
// Output checker: compares AN codes, vcount and strobe counts of each display-list
// instruction against the expected values
`timescale 1ns/100ps
`default_nettype none

module anChecker (
  input  logic        Fphi0,
  input  logic        rst,
  input  logic        dma,
  input  logic        rdy,
  input  logic [3:0]  an,
  input  logic [7:0]  vcount,
  input  logic        loadIr,
  input  logic        loadDlistL,
  input  logic        loadDlistH,
  input  logic        loadDlist,
  input  logic        dlistEnd,
  input  logic        loadMsrL,
  input  logic        loadMsrH,
  input  logic        loadMsrData,
  input  logic        loadPtr,
  input  logic        incrMsr,
  input  logic        loadChar,
  input  logic        updateWsync,
  input  logic        msrDataRdy,
  input  logic [7:0]  msrData,
  input  logic [63:0] charData,
  input  logic        isChar,
  input  logic        entryStart,
  input  logic        entryEnd,
  input  int          expPixels,
  input  int          expLoadIr,
  input  logic [7:0]  expVcount,
  input  logic        expJump,
  input  logic        expEnd,
  input  logic        expMsrLoad,
  input  int          expBytes,
  input  int          expWsync,
  output int          errorCount
);
  import gtiaPkg::*;

  int         pixCnt;
  int         irCnt;
  int         dlLoCnt;
  int         dlHiCnt;
  int         dlCnt;
  int         endCnt;
  int         msrLoCnt;
  int         msrHiCnt;
  int         ptrCnt;
  int         incrCnt;
  int         charCnt;
  int         wsyncCnt;
  logic [7:0] mapByte;

  // Map pixel k takes bit 2k as its high bit and bit 2k+1 as its low bit
  function automatic logic [3:0] expectedMap(input logic [7:0] b, input int idx);
    int k;
    k = idx / 2;
    case ({b[2*k], b[2*k+1]})
      2'd0:    return anBackground;
      2'd1:    return anPlayfield0;
      2'd2:    return anPlayfield1;
      default: return anPlayfield2;
    endcase
  endfunction

  task automatic checkCount(input string name, input int got, input int want);
    if (got != want) begin
      $display("Error %s count: got %h expected %h", name, got, want);
      errorCount++;
    end
  endtask

  always @(posedge Fphi0) begin
    logic       adv;
    logic [3:0] want;
    adv = !(dma && !rdy);
    if (rst) begin
      errorCount = 0;
      pixCnt     = 0;
      mapByte    = 8'h00;
    end else begin
      if (entryStart) begin
        pixCnt   = 0;
        irCnt    = 0;
        dlLoCnt  = 0;
        dlHiCnt  = 0;
        dlCnt    = 0;
        endCnt   = 0;
        msrLoCnt = 0;
        msrHiCnt = 0;
        ptrCnt   = 0;
        incrCnt  = 0;
        charCnt  = 0;
        wsyncCnt = 0;
      end
      if (an != anNone) begin
        if (isChar) begin
          want = charData[pixCnt % 64] ? anPlayfield1 : anPlayfield2;
        end else begin
          want = expectedMap(mapByte, pixCnt % 8);
        end
        if (an != want) begin
          $display("Error an: got %h expected %h at pixel %0d", an, want, pixCnt);
          errorCount++;
        end
        pixCnt++;
      end
      // Strobes count once, on the advancing cycle that ends them
      if (adv) begin
        if (loadMsrH && msrLoCnt == 0) begin
          $display("Memory-scan high byte was loaded before the low byte");
          errorCount++;
        end
        if (loadMsrData && expMsrLoad && msrHiCnt == 0) begin
          $display("Memory-scan data was fetched before the scan address was loaded");
          errorCount++;
        end
        irCnt    += int'(loadIr);
        dlLoCnt  += int'(loadDlistL);
        dlHiCnt  += int'(loadDlistH);
        dlCnt    += int'(loadDlist);
        endCnt   += int'(dlistEnd);
        msrLoCnt += int'(loadMsrL);
        msrHiCnt += int'(loadMsrH);
        ptrCnt   += int'(loadPtr);
        incrCnt  += int'(incrMsr);
        charCnt  += int'(loadChar);
        wsyncCnt += int'(updateWsync);
        if (msrDataRdy) begin
          mapByte = msrData;
        end
      end
      if (entryEnd) begin
        checkCount("pixel", pixCnt, expPixels);
        checkCount("loadIr", irCnt, expLoadIr);
        checkCount("loadDlistL", dlLoCnt, int'(expJump));
        checkCount("loadDlistH", dlHiCnt, int'(expJump));
        checkCount("loadDlist", dlCnt, int'(expJump));
        checkCount("loadPtr", ptrCnt, int'(expJump));
        checkCount("dlistEnd", endCnt, int'(expEnd));
        checkCount("loadMsrL", msrLoCnt, int'(expMsrLoad));
        checkCount("loadMsrH", msrHiCnt, int'(expMsrLoad));
        checkCount("incrMsr", incrCnt, expBytes);
        checkCount("loadChar", charCnt, isChar ? expBytes : 0);
        checkCount("updateWsync", wsyncCnt, expWsync);
        if (vcount != expVcount) begin
          $display("Error vcount: got %h expected %h", vcount, expVcount);
          errorCount++;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/tbTop.sv */
// Testbench top: clock, reset, memory responders, stall driver, stimulus table
// and the DUT instance
`timescale 1ns/100ps
`default_nettype none

module tbTop;
  localparam int entries = 8;
  localparam int readyLimit = 1000;
  localparam int lineLimit = 20000;
  localparam int vblankLen = 20;

  logic Fphi0, rst, irRdy, msrDataRdy, charLoaded, dma, rdy;
  logic [7:0] ir, dmactl, msrData, vcount;
  logic [63:0] charData;
  logic loadIr, loadDlistL, loadDlistH, loadPtr, loadDlist, loadMsrL, loadMsrH;
  logic loadMsrData, incrMsr, loadChar, updateWsync, dlistEnd;
  logic [3:0] an;
  logic isChar, entryStart, entryEnd, expJump, expEnd, expMsrLoad, stallOn;
  logic [7:0] expVcount;
  int expPixels, expLoadIr, expBytes, expWsync, errorCount, timeouts, fetchIdx;
  logic [7:0] msrBase;

  // Columns: ir, operand bytes, dmactl, map base byte, charData, stall, then expected
  // pixels, vcount step, vcount clear, jump strobes, dlistEnd and memory-scan load
  logic [7:0] tIr [entries], tOp0 [entries], tOp1 [entries], tDmactl [entries];
  logic [7:0] tMsr [entries], tDelta [entries];
  logic [63:0] tChar [entries];
  logic tStall [entries], tClear [entries], tJump [entries], tEnd [entries], tMsrLd [entries];
  int tPix [entries];

  dataTranslate #(.vblankCycles(vblankLen)) dut0 (.*);

  anChecker checker0 (.*);

  always #50 Fphi0 = ~Fphi0;

  function automatic logic advNow();
    return !(dma && !rdy);
  endfunction

  task automatic setEntry(input int i, input logic [7:0] irv, op0, op1, dmv, msrv,
                          input logic [63:0] chr, input logic stall, input int pix,
                          input logic [7:0] delta, input logic clr, jmp, fin, msrLd);
    tIr[i] = irv;
    tOp0[i] = op0;
    tOp1[i] = op1;
    tDmactl[i] = dmv;
    tMsr[i] = msrv;
    tChar[i] = chr;
    tStall[i] = stall;
    tPix[i] = pix;
    tDelta[i] = delta;
    tClear[i] = clr;
    tJump[i] = jmp;
    tEnd[i] = fin;
    tMsrLd[i] = msrLd;
  endtask

  task automatic loadTable();
    setEntry(0, 8'h30, 0, 0, 8'h22, 0, 64'h0, 0, 0, 8'd4, 0, 0, 0, 0);
    setEntry(1, 8'h02, 0, 0, 8'h22, 0, 64'hA5C3_0F00_FF12_8001, 0, 2560, 8'd8, 0, 0, 0, 0);
    setEntry(2, 8'h4E, 8'h00, 8'h30, 8'h21, 8'h1B, 64'h0, 0, 256, 8'd1, 0, 0, 0, 1);
    setEntry(3, 8'h0E, 0, 0, 8'h21, 8'h6C, 64'h0, 1, 256, 8'd1, 0, 0, 0, 0);
    setEntry(4, 8'h02, 0, 0, 8'h22, 0, 64'h0123_4567_89AB_CDEF, 1, 2560, 8'd8, 0, 0, 0, 0);
    setEntry(5, 8'h00, 0, 0, 8'h22, 0, 64'h0, 0, 0, 8'd1, 0, 0, 0, 0);
    setEntry(6, 8'h01, 8'h40, 8'h20, 8'h22, 0, 64'h0, 0, 0, 8'd0, 0, 1, 0, 0);
    setEntry(7, 8'h41, 8'h00, 8'h20, 8'h22, 0, 64'h0, 0, 0, 8'd0, 1, 1, 1, 0);
  endtask

  // Waits for an advancing edge, which is where the DUT takes a ready flag
  task automatic waitTaken(input string what);
    int n;
    n = 0;
    do begin
      @(posedge Fphi0);
      n++;
    end while (!advNow() && n < readyLimit);
    if (!advNow()) begin
      $display("Timed out waiting for the DUT to take %s", what);
      timeouts++;
    end
  endtask

  task automatic waitLoadIr(input int limit);
    int n;
    n = 0;
    do begin
      @(posedge Fphi0);
      n++;
    end while (!(loadIr && advNow()) && n < limit);
    if (!(loadIr && advNow())) begin
      $display("Timed out waiting for loadIr");
      timeouts++;
    end
  endtask

  always @(posedge Fphi0) begin
    dma <= stallOn;
    rdy <= stallOn ? (($urandom % 4) != 0) : 1'b1;
  end

  initial begin
    int d;
    forever begin
      @(posedge Fphi0);
      if (!rst && loadMsrData && advNow()) begin
        d = ($urandom % 3) + 1;
        repeat (d - 1) @(posedge Fphi0);
        msrData    <= msrBase + 8'(fetchIdx * 37);
        fetchIdx++;
        msrDataRdy <= 1'b1;
        waitTaken("msrDataRdy");
        msrDataRdy <= 1'b0;
      end
    end
  end

  initial begin
    int d;
    forever begin
      @(posedge Fphi0);
      if (!rst && loadChar && advNow()) begin
        d = ($urandom % 3) + 1;
        repeat (d - 1) @(posedge Fphi0);
        charLoaded <= 1'b1;
        waitTaken("charLoaded");
        charLoaded <= 1'b0;
      end
    end
  end

  initial begin
    int i, k, ops;
    logic [7:0] vExp;
    logic modeLine;
    Fphi0 = 0;
    rst = 1;
    ir = 0;
    irRdy = 0;
    dmactl = 0;
    msrData = 0;
    msrDataRdy = 0;
    charData = 0;
    charLoaded = 0;
    dma = 0;
    rdy = 1;
    stallOn = 0;
    isChar = 0;
    entryStart = 0;
    entryEnd = 0;
    expPixels = 0;
    expLoadIr = 0;
    expBytes = 0;
    expWsync = 0;
    expVcount = 0;
    expJump = 0;
    expEnd = 0;
    expMsrLoad = 0;
    timeouts = 0;
    fetchIdx = 0;
    msrBase = 0;
    vExp = 0;
    void'($urandom(99));
    loadTable();
    repeat (4) @(posedge Fphi0);
    rst <= 1'b0;
    @(posedge Fphi0);
    for (i = 0; i < entries && timeouts == 0; i++) begin
      ops      = (tJump[i] || tMsrLd[i]) ? 2 : 0;
      modeLine = (tIr[i][3:0] == 4'd2) || (tIr[i][3:0] == 4'd14);
      vExp     = tClear[i] ? 8'd0 : vExp + tDelta[i];
      @(posedge Fphi0);
      entryStart <= 1'b1;
      dmactl     <= tDmactl[i];
      charData   <= tChar[i];
      isChar     <= (tIr[i][3:0] == 4'd2);
      stallOn    <= tStall[i];
      msrBase    <= tMsr[i];
      fetchIdx   = 0;
      expPixels  <= tPix[i];
      expLoadIr  <= 1 + ops;
      expVcount  <= vExp;
      expJump    <= tJump[i];
      expEnd     <= tEnd[i];
      expMsrLoad <= tMsrLd[i];
      // A character byte gives 64 pixels, a map byte 8
      expBytes   <= (tIr[i][3:0] == 4'd2) ? tPix[i] / 64 : tPix[i] / 8;
      // Sync is held through the vertical-blank wait and pulses once per mode line
      expWsync   <= tEnd[i] ? vblankLen : (modeLine ? 1 : 0);
      @(posedge Fphi0);
      entryStart <= 1'b0;
      ir         <= tIr[i];
      irRdy      <= 1'b1;
      waitTaken("the instruction");
      irRdy <= 1'b0;
      for (k = 0; k < ops && timeouts == 0; k++) begin
        waitLoadIr(readyLimit);
        ir    <= (k == 0) ? tOp0[i] : tOp1[i];
        irRdy <= 1'b1;
        waitTaken("an operand");
        irRdy <= 1'b0;
      end
      waitLoadIr(lineLimit);
      entryEnd <= 1'b1;
      @(posedge Fphi0);
      entryEnd <= 1'b0;
    end
    stallOn <= 1'b0;
    repeat (4) @(posedge Fphi0);
    $display("Closing count: %0d check errors, %0d timeouts", errorCount, timeouts);
    if (errorCount == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/anticPkg.sv
design/gtiaPkg.sv
design/modeLineIf.sv
design/dlistSequencer.sv
design/playfieldSerializer.sv
design/scanlineOutput.sv
design/dataTranslate.sv
verif/anChecker.sv
verif/tbTop.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       ?= tbTop
FLIST     ?= flist.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
